//--- list.f
+incdir+logic
logic/armCtrlPkg.sv
logic/instrDecoder.sv
logic/aluDecoder.sv
logic/condUnit.sv
logic/memMask.sv
logic/pipeCtrl.sv
logic/hazardUnit.sv
logic/ctrlTop.sv
dv/ctrlTb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ctrlTb -f list.f -o simCtrl \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/simCtrl > sim.log 2>&1
cat sim.log
grep -q "PASS: all tests" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- dv/ctrlTb.sv
`timescale 1ns/1ps

module ctrlTb import armCtrlPkg::*; ();

  localparam int numInstr  = 400;
  localparam int clkPeriod = 4;

  typedef enum logic [2:0] {dpReg, dpImm, wordMem, halfMem, branchB, branchX} kindT;

  // Expected control bits of one stage
  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       pcSrc;
    logic       isMem;
    logic [3:0] mask;
  } stageExpT;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] instrD = 32'hE1A00000;  // MOV r0, r0
  logic [3:0]  flagsE = 4'h0;
  logic [1:0]  aluResultLowE = 2'b00;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  execCtrlT    execCtrlE;
  aluCtrlE     aluControlE;
  logic        branchTakenE;
  memCtrlT     memCtrlM;
  wbCtrlT      wbCtrlW;
  logic        pcWrPendingF;
  logic [3:0]  flagsOut;
  logic        stallF;
  logic        stallD;
  logic        flushD;

  kindT        kindD = dpReg;
  logic [31:0] lfsr = 32'heee1;
  logic [3:0]  lastRd = 4'h0;
  int          issued = 0;
  int          stallSeen = 0;
  int          branchSeen = 0;

  // Reference model
  logic [31:0] mInstrE;
  kindT        mKindE;
  logic        mValidE;
  logic [3:0]  mFlags;
  stageExpT    mM;
  stageExpT    mW;
  stageExpT    eNext;
  logic        ePass;
  logic        isDpE;
  logic        isLoadE;
  logic        expBt;
  logic        expLoadUse;
  logic        expPending;
  logic [1:0]  expRegSrc;
  logic [1:0]  expImmSrc;
  logic        expAluSrc;

  ctrlTop i_ctrlTop (.*);

  initial forever #(clkPeriod / 2) clk = ~clk;

  // Galois LFSR, one step per bit drawn
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic condPass(input logic [3:0] cond, input logic [3:0] f);
    logic base;
    case (cond[3:1])
      3'b000:  base = f[2];  // Z
      3'b001:  base = f[1];  // C
      3'b010:  base = f[3];  // N
      3'b011:  base = f[0];  // V
      3'b100:  base = f[1] & ~f[2];
      3'b101:  base = (f[3] == f[0]);
      3'b110:  base = ~f[2] & (f[3] == f[0]);
      default: base = 1'b1;
    endcase
    // Odd codes test the inverse, al always passes
    return (cond == 4'hE) ? 1'b1 : base ^ cond[0];
  endfunction

  // Register writes aimed at r15
  function automatic logic writesPc(input kindT kind, input logic [31:0] instr);
    return ((kind inside {dpReg, dpImm}) || (kind inside {wordMem, halfMem} && instr[20]))
           && instr[15:12] == 4'hF;
  endfunction

  task automatic stopOnError();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic reportError(input string sigName, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, sigName, expVal, actVal);
    stopOnError();
  endtask

  task automatic makeInstr(output logic [31:0] instr, output kindT kind);
    logic [2:0] pick;
    logic [3:0] cond;
    logic [3:0] opc;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rm;
    logic       s;
    logic       u;
    logic       l;
    logic       b;
    pick = 3'(randBits(3));
    cond = (randBits(1) != 0) ? 4'hE : 4'(randBits(4));
    if (cond == 4'hF)
      cond = 4'hE;
    opc = 4'(randBits(4));
    s   = 1'(randBits(1));
    rn  = 4'(randBits(4));
    rd  = 4'(randBits(4));
    rm  = 4'(randBits(4));
    if (2'(randBits(2)) == 2'b00)
      rn = lastRd;  // Dependent on the previous Rd
    u = 1'(randBits(1));
    l = 1'(randBits(1));
    b = 1'(randBits(1));
    case (pick)
      3'd1: begin
        kind  = dpImm;
        instr = {cond, 3'b001, opc, s, rn, rd, 12'(randBits(12))};
      end
      3'd2: begin
        kind  = wordMem;  // Pre-indexed, immediate offset
        instr = {cond, 3'b010, 1'b1, u, b, 1'b0, l, rn, rd, 12'(randBits(12))};
      end
      3'd3: begin
        kind  = halfMem;
        instr = {cond, 3'b000, 1'b1, u, 1'b1, 1'b0, l, rn, rd, 4'(randBits(4)), 4'b1011,
                 4'(randBits(4))};
      end
      3'd4: begin
        kind  = branchB;
        instr = {cond, 4'b1010, 24'(randBits(24))};
      end
      3'd5: begin
        kind  = branchX;
        instr = {cond, 24'h12FFF1, rm};
      end
      default: begin
        kind  = dpReg;
        instr = {cond, 3'b000, opc, s, rn, rd, 8'h00, rm};
      end
    endcase
    lastRd = rd;
  endtask

  // ==========================================================================
  // Reference model of D, E, M and W
  // ==========================================================================
  always_comb begin
    ePass      = condPass(mInstrE[31:28], mFlags);
    isDpE      = mKindE inside {dpReg, dpImm};
    isLoadE    = (mKindE inside {wordMem, halfMem}) && mInstrE[20];
    expBt      = mValidE && (mKindE inside {branchB, branchX}) && ePass;
    expLoadUse = mValidE && isLoadE &&
                 (mInstrE[15:12] == instrD[19:16] || mInstrE[15:12] == instrD[3:0]);
    eNext          = '0;
    // Test and compare opcodes are 10xx
    eNext.regWrite = mValidE && ePass && ((isDpE && mInstrE[24:23] != 2'b10) || isLoadE);
    eNext.memWrite = mValidE && ePass && (mKindE inside {wordMem, halfMem}) && !mInstrE[20];
    eNext.pcSrc    = eNext.regWrite && mInstrE[15:12] == 4'hF;
    eNext.isMem    = mValidE && (mKindE inside {wordMem, halfMem});
    if (mKindE == halfMem)
      eNext.mask = aluResultLowE[1] ? 4'b1100 : 4'b0011;
    else if (mKindE == wordMem && mInstrE[22])
      eNext.mask = 4'b0001 << aluResultLowE;  // Byte lane
    else
      eNext.mask = 4'b1111;
    expPending = writesPc(kindD, instrD) || (mValidE && writesPc(mKindE, mInstrE)) || mM.pcSrc;
    // Stores read Rd as a source, branches read the PC
    expRegSrc = {(kindD inside {wordMem, halfMem}) && !instrD[20],
                 kindD inside {branchB, branchX}};
    case (kindD)
      wordMem: expImmSrc = 2'b01;
      halfMem: expImmSrc = 2'b11;
      branchB: expImmSrc = 2'b10;
      default: expImmSrc = 2'b00;
    endcase
    // Immediate operand for DP immediate, offset transfers and B
    expAluSrc = mKindE inside {dpImm, wordMem, halfMem, branchB};
  end

  always @(posedge clk) begin
    if (rst) begin
      mValidE <= 1'b0;
      mInstrE <= '0;
      mKindE  <= dpReg;
      mFlags  <= 4'h0;
      mM      <= '0;
      mW      <= '0;
    end else begin
      mM <= eNext;
      mW <= mM;
      if (mValidE && isDpE && mInstrE[20] && ePass)
        mFlags <= flagsE;  // S bit, condition passed
      if (expBt || expLoadUse) begin
        mValidE <= 1'b0;
      end else begin
        mValidE <= 1'b1;
        mInstrE <= instrD;
        mKindE  <= kindD;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && expLoadUse)
      stallSeen++;
    if (!rst && expBt)
      branchSeen++;
  end

  // ==========================================================================
  // Checks, sampled mid-cycle
  // ==========================================================================
  assert property (@(negedge clk) rst |-> (!memCtrlM.regWrite && !memCtrlM.memWrite &&
      !wbCtrlW.regWrite && !wbCtrlW.pcSrc && !branchTakenE && flagsOut == 4'h0))
    else begin
      $display("Control outputs are not cleared while reset is held");
      stopOnError();
    end
  assert property (@(negedge clk) regSrcD == expRegSrc)
    else reportError("regSrcD", 32'(expRegSrc), 32'(regSrcD));
  assert property (@(negedge clk) immSrcD == expImmSrc)
    else reportError("immSrcD", 32'(expImmSrc), 32'(immSrcD));
  assert property (@(negedge clk) mValidE |-> execCtrlE.aluSrc == expAluSrc)
    else reportError("execCtrlE.aluSrc", 32'(expAluSrc), 32'(execCtrlE.aluSrc));
  assert property (@(negedge clk) mValidE |-> !execCtrlE.multSelect)
    else reportError("execCtrlE.multSelect", 32'(0), 32'(execCtrlE.multSelect));
  assert property (@(negedge clk) mValidE && isDpE |-> aluControlE == mInstrE[24:21])
    else reportError("aluControlE", 32'(mInstrE[24:21]), 32'(aluControlE));
  assert property (@(negedge clk) branchTakenE == expBt)
    else reportError("branchTakenE", 32'(expBt), 32'(branchTakenE));
  assert property (@(negedge clk) flushD == expBt)
    else reportError("flushD", 32'(expBt), 32'(flushD));
  assert property (@(negedge clk) stallD == expLoadUse)
    else reportError("stallD", 32'(expLoadUse), 32'(stallD));
  assert property (@(negedge clk) stallF == expLoadUse)
    else reportError("stallF", 32'(expLoadUse), 32'(stallF));
  assert property (@(negedge clk) flagsOut == mFlags)
    else reportError("flagsOut", 32'(mFlags), 32'(flagsOut));
  assert property (@(negedge clk) memCtrlM.regWrite == mM.regWrite)
    else reportError("memCtrlM.regWrite", 32'(mM.regWrite), 32'(memCtrlM.regWrite));
  assert property (@(negedge clk) memCtrlM.memWrite == mM.memWrite)
    else reportError("memCtrlM.memWrite", 32'(mM.memWrite), 32'(memCtrlM.memWrite));
  assert property (@(negedge clk) memCtrlM.pcSrc == mM.pcSrc)
    else reportError("memCtrlM.pcSrc", 32'(mM.pcSrc), 32'(memCtrlM.pcSrc));
  assert property (@(negedge clk) mM.isMem |-> memCtrlM.byteMask == mM.mask)
    else reportError("memCtrlM.byteMask", 32'(mM.mask), 32'(memCtrlM.byteMask));
  assert property (@(negedge clk) wbCtrlW.regWrite == mW.regWrite)
    else reportError("wbCtrlW.regWrite", 32'(mW.regWrite), 32'(wbCtrlW.regWrite));
  assert property (@(negedge clk) wbCtrlW.pcSrc == mW.pcSrc)
    else reportError("wbCtrlW.pcSrc", 32'(mW.pcSrc), 32'(wbCtrlW.pcSrc));
  assert property (@(negedge clk) pcWrPendingF == expPending)
    else reportError("pcWrPendingF", 32'(expPending), 32'(pcWrPendingF));

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    logic [31:0] nextInstr;
    kindT        nextKind;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    while (issued < numInstr) begin
      @(posedge clk);
      flagsE        <= 4'(randBits(4));
      aluResultLowE <= 2'(randBits(2));
      // D holds while the hazard unit stalls it
      if (!stallD) begin
        makeInstr(nextInstr, nextKind);
        instrD <= nextInstr;
        kindD  <= nextKind;
        issued++;
      end
    end
    repeat (6) @(posedge clk);  // Drain to W
    if (stallSeen == 0 || branchSeen == 0) begin
      $display("Stimulus produced no load-use stall or no taken branch");
      stopOnError();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  initial begin
    #(numInstr * clkPeriod * 8);
    $display("Timeout: the instruction stream did not complete in time");
    stopOnError();
  end

endmodule

//--- logic/ctrlTop.sv
`timescale 1ns/1ps
`include "armCtrl_defs.svh"

module ctrlTop import armCtrlPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [3:0]          flagsE,
  input  logic [1:0]          aluResultLowE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output execCtrlT            execCtrlE,
  output aluCtrlE             aluControlE,
  output logic                branchTakenE,
  output memCtrlT             memCtrlM,
  output wbCtrlT              wbCtrlW,
  output logic                pcWrPendingF,
  output logic [3:0]          flagsOut,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD
);

  logic [`INSTR_W-1:0] instrE;
  logic                memtoRegE;
  logic                regWriteE;
  logic                flushE;

  pipeCtrl i_pipeCtrl (
    .clk, .rst, .instrD, .flagsE, .aluResultLowE, .stallD, .flushE,
    .regSrcD, .immSrcD, .instrE, .execCtrlE, .aluControlE, .memtoRegE,
    .regWriteE, .branchTakenE, .memCtrlM, .wbCtrlW, .pcWrPendingF, .flagsOut
  );

  hazardUnit i_hazardUnit (
    .instrD, .instrE, .memtoRegE, .regWriteE, .branchTakenE,
    .stallF, .stallD, .flushD, .flushE
  );

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps
`include "armCtrl_defs.svh"

module hazardUnit (
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [`INSTR_W-1:0] instrE,
  input  logic                memtoRegE,
  input  logic                regWriteE,
  input  logic                branchTakenE,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD,
  output logic                flushE
);

  logic [`REG_W-1:0] rdE;
  logic [`REG_W-1:0] rnD;
  logic [`REG_W-1:0] rmD;
  logic              loadUse;

  assign rdE = instrE[`RD_MSB -: `REG_W];
  assign rnD = instrD[`RN_MSB -: `REG_W];
  assign rmD = instrD[`RM_MSB -: `REG_W];

  // Load result not ready for the next instruction
  assign loadUse = memtoRegE & regWriteE & ((rdE == rnD) | (rdE == rmD));

  assign stallF = loadUse;
  assign stallD = loadUse;

  // Taken branch kills the younger instructions
  assign flushD = branchTakenE;
  assign flushE = loadUse | branchTakenE;  // Bubble into E

endmodule

//--- logic/pipeCtrl.sv
`timescale 1ns/1ps
`include "armCtrl_defs.svh"

module pipeCtrl import armCtrlPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [3:0]          flagsE,
  input  logic [1:0]          aluResultLowE,
  input  logic                stallD,
  input  logic                flushE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic [`INSTR_W-1:0] instrE,
  output execCtrlT            execCtrlE,
  output aluCtrlE             aluControlE,
  output logic                memtoRegE,
  output logic                regWriteE,
  output logic                branchTakenE,
  output memCtrlT             memCtrlM,
  output wbCtrlT              wbCtrlW,
  output logic                pcWrPendingF,
  output logic [3:0]          flagsOut
);

  decodeCtrlT ctrlD;
  decodeCtrlT ctrlE;
  execCtrlT   aluExecCtrl;
  memCtrlT    memCtrlE;
  condE       condFieldE;
  logic       validE;
  logic       condExE;
  logic       doNotWriteRegE;
  logic       byteOrWordE;
  logic       halfwordE;
  logic       halfwordOffsetE;
  logic       halfwordOffsetM;
  logic [3:0] byteMaskE;

  instrDecoder i_instrDecoder (.instrD, .ctrlD, .regSrcD, .immSrcD);

  // ==========================================================================
  // D to E, flush wins over stall
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      ctrlE  <= '0;
      instrE <= '0;
      validE <= 1'b0;
    end else if (!stallD) begin
      ctrlE  <= ctrlD;
      instrE <= instrD;
      validE <= 1'b1;
    end
  end

  // ==========================================================================
  // Execute
  // ==========================================================================
  assign condFieldE = condE'(instrE[`COND_MSB:`COND_LSB]);

  condUnit i_condUnit (
    .clk, .rst, .en(validE), .cond(condFieldE), .flagsE,
    .flagWrite(ctrlE.flagWrite), .condEx(condExE), .flags(flagsOut)
  );

  aluDecoder i_aluDecoder (
    .aluOp(ctrlE.aluOp), .aluControl(ctrlE.aluControl), .carryIn(flagsOut[1]),
    .bx(ctrlE.bx), .execCtrl(aluExecCtrl), .doNotWriteReg(doNotWriteRegE)
  );

  always_comb begin
    execCtrlE            = aluExecCtrl;
    execCtrlE.aluSrc     = ctrlE.aluSrc;
    execCtrlE.multSelect = ctrlE.multSelect;
  end

  assign byteOrWordE = (instrE[27:26] == 2'b01) & instrE[22];  // LDRB or STRB
  assign halfwordE   = ctrlE.halfword & instrE[5];  // H bit of SH

  memMask i_memMask (
    .byteOrWord(byteOrWordE), .halfword(halfwordE), .addrLow(aluResultLowE),
    .byteMask(byteMaskE), .halfwordOffset(halfwordOffsetE)
  );

  // Condition gating
  always_comb begin
    memCtrlE.memWrite      = ctrlE.memWrite & condExE;
    memCtrlE.memtoReg      = ctrlE.memtoReg;
    memCtrlE.regWrite      = ctrlE.regWrite & condExE & ~doNotWriteRegE;
    memCtrlE.pcSrc         = ctrlE.pcSrc & condExE & ~doNotWriteRegE;
    memCtrlE.byteMask      = byteMaskE;
    memCtrlE.byteOrWord    = byteOrWordE;
    memCtrlE.byteOffset    = aluResultLowE;
    memCtrlE.writeHalfword = ctrlE.halfword;
  end

  assign branchTakenE = ctrlE.branch & condExE;
  assign memtoRegE    = ctrlE.memtoReg;
  assign regWriteE    = ctrlE.regWrite;  // Ungated, seen by the hazard unit
  assign aluControlE  = ctrlE.aluControl;

  // ==========================================================================
  // E to M and M to W
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      memCtrlM        <= '0;
      halfwordOffsetM <= 1'b0;
      wbCtrlW         <= '0;
    end else begin
      memCtrlM        <= memCtrlE;
      halfwordOffsetM <= halfwordOffsetE;
      wbCtrlW         <= '{memtoReg:       memCtrlM.memtoReg,
                           regWrite:       memCtrlM.regWrite,
                           pcSrc:          memCtrlM.pcSrc,
                           loadLength:     memCtrlM.byteOrWord,
                           byteOffset:     memCtrlM.byteOffset,
                           writeHalfword:  memCtrlM.writeHalfword,
                           halfwordOffset: halfwordOffsetM};
    end
  end

  // Fetch holds off while a PC write is in flight
  assign pcWrPendingF = ctrlD.pcSrc | ctrlE.pcSrc | memCtrlM.pcSrc;

endmodule

//--- logic/memMask.sv
`timescale 1ns/1ps

module memMask (
  input  logic       byteOrWord,
  input  logic       halfword,
  input  logic [1:0] addrLow,
  output logic [3:0] byteMask,
  output logic       halfwordOffset
);

  // Upper or lower halfword of the addressed word
  assign halfwordOffset = halfword & addrLow[1];

  always_comb begin
    if (byteOrWord) begin
      byteMask = 4'b0001 << addrLow;  // One lane per byte address
    end else if (halfword) begin
      byteMask = halfwordOffset ? 4'b1100 : 4'b0011;
    end else begin
      byteMask = 4'b1111;
    end
  end

endmodule

//--- logic/condUnit.sv
`timescale 1ns/1ps

module condUnit import armCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       en,
  input  condE       cond,
  input  logic [3:0] flagsE,
  input  logic [1:0] flagWrite,
  output logic       condEx,
  output logic [3:0] flags
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flags;

  // Evaluated against the flags held before this instruction
  always_comb begin
    case (cond)
      eq: condEx = z;
      ne: condEx = ~z;
      cs: condEx = c;
      cc: condEx = ~c;
      mi: condEx = n;
      pl: condEx = ~n;
      vs: condEx = v;
      vc: condEx = ~v;
      hi: condEx = c & ~z;
      ls: condEx = ~c | z;
      ge: condEx = (n == v);
      lt: condEx = (n != v);
      gt: condEx = ~z & (n == v);
      le: condEx = z | (n != v);
      al: condEx = 1'b1;
      default: condEx = 1'b0;  // 4'b1111 never executes
    endcase
  end

  // NZ and CV update independently
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (en && condEx) begin
      if (flagWrite[1]) flags[3:2] <= flagsE[3:2];
      if (flagWrite[0]) flags[1:0] <= flagsE[1:0];
    end
  end

endmodule

//--- logic/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder import armCtrlPkg::*; (
  input  logic     aluOp,
  input  aluCtrlE  aluControl,
  input  logic     carryIn,
  input  logic     bx,
  output execCtrlT execCtrl,
  output logic     doNotWriteReg
);

  always_comb begin
    execCtrl = '0;  // aluSrc and multSelect are filled in by the pipeline
    execCtrl.aluOperation = opAdd;  // Address and branch target add
    doNotWriteReg = 1'b0;

    if (bx) begin
      execCtrl.aluOperation = opPass;  // Rm straight to PC
    end else if (aluOp) begin
      case (aluControl)
        andOp, tstOp: {execCtrl.aluOperation, execCtrl.cvUpdate} = {opAnd, 3'b010};
        eorOp, teqOp: {execCtrl.aluOperation, execCtrl.cvUpdate} = {opXor, 3'b010};
        subOp, cmpOp: {execCtrl.aluOperation, execCtrl.cvUpdate} = {opSub, 3'b101};
        addOp, cmnOp: {execCtrl.aluOperation, execCtrl.cvUpdate} = {opAdd, 3'b101};
        orrOp:        {execCtrl.aluOperation, execCtrl.cvUpdate} = {opOr, 3'b010};
        movOp:        {execCtrl.aluOperation, execCtrl.cvUpdate} = {opPass, 3'b010};
        rsbOp: begin
          {execCtrl.aluOperation, execCtrl.cvUpdate} = {opSub, 3'b101};
          execCtrl.reverseInputs = 1'b1;
        end
        // Carry-chained forms run through the adder with B inverted as needed
        adcOp: {execCtrl.cvUpdate, execCtrl.aluCarry} = {3'b101, carryIn};
        sbcOp: {execCtrl.cvUpdate, execCtrl.invertB, execCtrl.aluCarry} = {3'b101, 1'b1, carryIn};
        rscOp: begin
          {execCtrl.cvUpdate, execCtrl.invertB, execCtrl.aluCarry} = {3'b101, 1'b1, carryIn};
          execCtrl.reverseInputs = 1'b1;
        end
        bicOp: {execCtrl.aluOperation, execCtrl.cvUpdate, execCtrl.invertB} = {opAnd, 3'b010, 1'b1};
        mvnOp: {execCtrl.aluOperation, execCtrl.cvUpdate, execCtrl.invertB} = {opPass, 3'b010, 1'b1};
        default: execCtrl.aluOperation = opAdd;
      endcase
      doNotWriteReg = aluControl inside {tstOp, teqOp, cmpOp, cmnOp};  // Flags only
    end
  end

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`include "armCtrl_defs.svh"

module instrDecoder import armCtrlPkg::*; (
  input  logic [`INSTR_W-1:0] instrD,
  output decodeCtrlT          ctrlD,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD
);

  logic              isDataProc;
  logic              isMult;
  logic              isHalfword;
  logic              isBx;
  logic              isMem;
  logic [10:0]       controls;
  logic [`REG_W-1:0] rd;

  // ==========================================================================
  // Instruction class
  // ==========================================================================
  assign isHalfword = (instrD[27:25] == 3'b000) & instrD[7] & instrD[4] &
                      (instrD[6:5] != 2'b00);
  assign isMult     = (instrD[27:22] == 6'b000000) & (instrD[7:4] == 4'b1001);
  assign isBx       = (instrD[27:4] == 24'h12_FFF1);
  assign isDataProc = (instrD[27:26] == 2'b00) & ~isMult & ~isHalfword & ~isBx;
  assign isMem      = (instrD[27:26] == 2'b01) | isHalfword;
  assign rd         = instrD[`RD_MSB -: `REG_W];

  // regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, multSelect, bx
  always_comb begin
    controls = '0;  // Coprocessor space decodes as a no-op
    case (instrD[27:26])
      2'b00: begin
        if (instrD[25])
          controls = {2'b00, 2'b00, 1'b1, 4'b0100, 2'b00};  // DP immediate
        else if (isMult)
          controls = {2'b00, 2'b00, 1'b0, 4'b0100, 2'b10};
        else if (isHalfword && instrD[20])
          controls = {2'b00, 2'b11, instrD[22], 4'b1100, 2'b00};  // LDRH
        else if (isHalfword)
          controls = {2'b10, 2'b11, instrD[22], 4'b0010, 2'b00};  // STRH
        else if (isBx)
          controls = {2'b01, 2'b00, 1'b0, 4'b0001, 2'b01};
        else
          controls = {2'b00, 2'b00, 1'b0, 4'b0100, 2'b00};  // DP register
      end
      // I bit is inverted for word transfers
      2'b01: begin
        if (instrD[20])
          controls = {2'b00, 2'b01, ~instrD[25], 4'b1100, 2'b00};
        else
          controls = {2'b10, 2'b01, ~instrD[25], 4'b0010, 2'b00};
      end
      2'b10: controls = {2'b01, 2'b10, 1'b1, 4'b0001, 2'b00};  // B
      default: controls = '0;
    endcase
  end

  // ==========================================================================
  // Control struct
  // ==========================================================================
  always_comb begin
    ctrlD = '0;
    {regSrcD, immSrcD, ctrlD.aluSrc, ctrlD.memtoReg, ctrlD.regWrite, ctrlD.memWrite,
     ctrlD.branch, ctrlD.multSelect, ctrlD.bx} = controls;
    ctrlD.halfword = isHalfword;
    ctrlD.aluOp    = isDataProc | isMult | isMem;

    if (isDataProc || isMult) begin
      ctrlD.aluControl = aluCtrlE'(instrD[24:21]);
      ctrlD.flagWrite  = {instrD[20], instrD[20] & ~isMult};  // MULS leaves C and V
    end else if (isMem) begin
      ctrlD.aluControl = instrD[23] ? addOp : subOp;  // U bit picks offset direction
    end else begin
      ctrlD.aluControl = addOp;
    end

    ctrlD.resultSelect = {ctrlD.multSelect, ctrlD.memtoReg};
    // Writes to r15 redirect fetch
    ctrlD.pcSrc = (rd == `PC_REG) & ctrlD.regWrite & ~ctrlD.multSelect;
  end

endmodule

//--- logic/armCtrlPkg.sv
package armCtrlPkg;

  // Data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    andOp = 4'b0000, eorOp, subOp, rsbOp, addOp, adcOp, sbcOp, rscOp,
    tstOp, teqOp, cmpOp, cmnOp, orrOp, movOp, bicOp, mvnOp
  } aluCtrlE;

  // Condition field, instruction bits 31:28
  typedef enum logic [3:0] {
    eq = 4'b0000, ne, cs, cc, mi, pl, vs, vc, hi, ls, ge, lt, gt, le, al
  } condE;

  typedef enum logic [2:0] {
    opAdd, opSub, opAnd, opOr, opXor, opPass
  } aluOpE;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       bx;
    logic       aluSrc;
    logic       aluOp;
    logic       multSelect;
    logic       halfword;
    logic [1:0] flagWrite;     // {NZ, CV}
    aluCtrlE    aluControl;
    logic [1:0] resultSelect;  // 00 ALU, 01 memory, 10 multiplier
    logic       pcSrc;
  } decodeCtrlT;

  typedef struct packed {
    aluOpE      aluOperation;
    logic [2:0] cvUpdate;      // {C from adder, C from shifter, V}
    logic       invertB;
    logic       reverseInputs;
    logic       aluCarry;
    logic       aluSrc;
    logic       multSelect;
  } execCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;
    logic       byteOrWord;
    logic [1:0] byteOffset;
    logic       writeHalfword;
  } memCtrlT;

  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadLength;
    logic [1:0] byteOffset;
    logic       writeHalfword;
    logic       halfwordOffset;
  } wbCtrlT;

endpackage

//--- logic/armCtrl_defs.svh
`ifndef ARMCTRL_DEFS_SVH
`define ARMCTRL_DEFS_SVH

// Datapath widths
`define INSTR_W 32
`define REG_W   4

// Instruction field positions
`define COND_MSB 31
`define COND_LSB 28
`define RN_MSB   19
`define RD_MSB   15
`define RM_MSB   3

// Register index of the program counter
`define PC_REG   4'hF

`endif
